// File: flist.f
source/taylor_pkg.sv
source/dsp_pair_if.sv
source/dsp_pair.sv
source/taylor_coefs.sv
source/taylor_engine.sv
source/request_queue.sv
source/taylor_top.sv
tb/taylor_checker.sv
tb/taylor_assert.sv
tb/taylor_tb.sv

// File: Makefile
SIM        := verilator
TOP        := taylor_tb
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "Test passed" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation reported failure"; \
		exit 1; \
	fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/taylor_tb.sv
// testbench top: clock, reset, credit-limited stimulus for the taylor unit and the final report
`timescale 1ns/1ps

module taylor_tb;
    import taylor_pkg::*;

    localparam int N_TERMS     = 10;
    localparam int QUEUE_DEPTH = 4;
    localparam int N_POINTS    = 5;
    localparam int N_RANDOM    = 200;
    localparam int N_MIDRUN    = 3;
    localparam int HALF_PI     = 102943;
    localparam int QUARTER_PI  = 51471;
    localparam int N_REQS      = 2 * N_POINTS + N_RANDOM + 2 * QUEUE_DEPTH + N_MIDRUN;
    localparam int TIMEOUT     = N_REQS * (N_TERMS * 4 + 20) + 200;

    localparam int PTS_L [N_POINTS] = '{0, QUARTER_PI, -QUARTER_PI, HALF_PI, -HALF_PI};
    localparam int PTS_R [N_POINTS] = '{QUARTER_PI, -QUARTER_PI, HALF_PI, -HALF_PI, 0};

    // the clock is named reset and the active-high reset is named clk
    logic                     reset = 1'b0;
    logic                     clk;
    logic                     i_req_valid;
    func_t                    i_func;
    logic signed [DATA_W-1:0] i_x_l;
    logic signed [DATA_W-1:0] i_x_r;
    logic                     o_credit;
    logic                     o_res_valid;
    logic signed [DATA_W-1:0] o_res_l;
    logic signed [DATA_W-1:0] o_res_r;

    int credits = QUEUE_DEPTH;
    int credit_pulses = 0;
    int sent = 0;
    int cycles = 0;
    int tb_errors = 0;
    int chk_errors;
    int chk_checked;
    int chk_pending;

    taylor_top dut_i (
        .reset(reset), .clk(clk),
        .i_req_valid(i_req_valid), .i_func(i_func), .i_x_l(i_x_l), .i_x_r(i_x_r),
        .o_credit(o_credit), .o_res_valid(o_res_valid), .o_res_l(o_res_l), .o_res_r(o_res_r)
    );

    taylor_checker #(.N_TERMS(N_TERMS)) checker_i (
        .reset(reset), .clk(clk),
        .i_req_valid(i_req_valid), .i_func(i_func), .i_x_l(i_x_l), .i_x_r(i_x_r),
        .i_res_valid(o_res_valid), .i_res_l(o_res_l), .i_res_r(o_res_r),
        .o_errors(chk_errors), .o_checked(chk_checked), .o_pending(chk_pending)
    );

    initial begin
        forever begin
            #2 reset = ~reset;
        end
    end

    // sender side credit count
    always @(posedge reset or posedge clk) begin
        if (clk) begin
            credits <= QUEUE_DEPTH;
        end else begin
            credits       <= credits + int'(o_credit) - int'(i_req_valid);
            credit_pulses <= credit_pulses + int'(o_credit);
        end
    end

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge reset);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("Test failed");
        $finish;
    end

    function automatic int total_errors();
        return tb_errors + chk_errors;
    endfunction

    function automatic int random_sample();
        return int'($urandom % (2 * HALF_PI + 1)) - HALF_PI;
    endfunction

    // tasks start and end just after a falling edge
    task automatic send_request(input func_t f, input int xl, input int xr);
        while (credits == 0) begin
            @(negedge reset);
        end
        i_req_valid = 1'b1;
        i_func      = f;
        i_x_l       = DATA_W'(xl);
        i_x_r       = DATA_W'(xr);
        sent++;
        @(negedge reset);
        i_req_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge reset);
    endtask

    task automatic apply_reset();
        i_req_valid = 1'b0;
        clk         = 1'b1;
        repeat (5) @(negedge reset);
        clk = 1'b0;
    endtask

    task automatic wait_idle();
        while (chk_pending != 0) begin
            @(negedge reset);
        end
    endtask

    task automatic check_count(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            tb_errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d (%s) done, %0d errors", num, name, total_errors() - errs_before);
    endtask

    task automatic run_fixed_points(input func_t f);
        for (int k = 0; k < N_POINTS; k++) begin
            send_request(f, PTS_L[k], PTS_R[k]);
        end
        wait_idle();
    endtask

    initial begin
        int errs;
        int checked0;
        int pulses0;
        int sent0;
        void'($urandom(32'h926a));
        clk         = 1'b1;
        i_req_valid = 1'b0;
        i_func      = FUNC_SIN;
        i_x_l       = '0;
        i_x_r       = '0;
        apply_reset();

        errs     = total_errors();
        checked0 = chk_checked;
        run_fixed_points(FUNC_SIN);
        check_count("sine results", chk_checked - checked0, N_POINTS);
        report_test(1, "sine at fixed points", errs);

        errs     = total_errors();
        checked0 = chk_checked;
        run_fixed_points(FUNC_COS);
        check_count("cosine results", chk_checked - checked0, N_POINTS);
        report_test(2, "cosine at fixed points", errs);

        errs     = total_errors();
        checked0 = chk_checked;
        for (int k = 0; k < N_RANDOM; k++) begin
            send_request(($urandom % 2 == 0) ? FUNC_SIN : FUNC_COS,
                         random_sample(), random_sample());
            idle_cycles($urandom % 4);
        end
        wait_idle();
        check_count("random results", chk_checked - checked0, N_RANDOM);
        report_test(3, "random traffic", errs);

        // whole credit pool in back-to-back cycles
        errs     = total_errors();
        checked0 = chk_checked;
        pulses0  = credit_pulses;
        sent0    = sent;
        for (int k = 0; k < QUEUE_DEPTH; k++) begin
            send_request((k % 2 == 0) ? FUNC_COS : FUNC_SIN, random_sample(), random_sample());
        end
        wait_idle();
        check_count("burst results", chk_checked - checked0, QUEUE_DEPTH);
        check_count("credit pulses", credit_pulses - pulses0, sent - sent0);
        check_count("final credits", credits, QUEUE_DEPTH);
        report_test(4, "credit flow", errs);

        // reset while the engine is busy
        errs = total_errors();
        for (int k = 0; k < N_MIDRUN; k++) begin
            send_request(FUNC_COS, random_sample(), random_sample());
        end
        idle_cycles(20);
        apply_reset();
        repeat (10) begin
            if (o_res_valid || o_credit) begin
                $display("%0t: result or credit output went active after the reset", $time);
                tb_errors++;
            end
            @(negedge reset);
        end
        checked0 = chk_checked;
        for (int k = 0; k < QUEUE_DEPTH; k++) begin
            send_request((k % 2 == 0) ? FUNC_SIN : FUNC_COS, random_sample(), random_sample());
        end
        wait_idle();
        check_count("results after reset", chk_checked - checked0, QUEUE_DEPTH);
        check_count("credits after reset", credits, QUEUE_DEPTH);
        report_test(5, "mid-run reset", errs);

        $display("tests: 5, results checked: %0d, errors: %0d", chk_checked, total_errors());
        if (total_errors() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb/taylor_assert.sv
// protocol checks on credits and result pulses, bound into the top level of the design
`timescale 1ns/1ps

module taylor_assert #(
    parameter int QUEUE_DEPTH = 4
) (
    input logic                                 reset,
    input logic                                 clk,
    input logic                                 i_req_valid,
    input logic                                 i_credit,
    input logic                                 i_res_valid,
    input logic signed [taylor_pkg::DATA_W-1:0] i_res_l,
    input logic signed [taylor_pkg::DATA_W-1:0] i_res_r,
    input logic [$clog2(QUEUE_DEPTH+1)-1:0]     i_count
);

    // reset is the clock here, clk the reset
    no_early_credit: assert property (@(posedge reset) $fell(clk) |=> !i_credit)
        else $error("a credit was returned in the first cycle after reset release");

    no_full_push: assert property (@(posedge reset) disable iff (clk)
        i_req_valid |-> (int'(i_count) != QUEUE_DEPTH))
        else $error("a request was pushed into a full queue");

    single_pulse: assert property (@(posedge reset) disable iff (clk)
        i_res_valid |=> !i_res_valid)
        else $error("result valid stayed high for two cycles");

    idle_zero: assert property (@(posedge reset) disable iff (clk)
        !i_res_valid |-> (i_res_l == '0 && i_res_r == '0))
        else $error("result values are not zero while no result is valid");

endmodule

bind taylor_top taylor_assert #(.QUEUE_DEPTH(QUEUE_DEPTH)) assert_i (
    .reset(reset), .clk(clk),
    .i_req_valid(i_req_valid), .i_credit(o_credit),
    .i_res_valid(o_res_valid), .i_res_l(o_res_l), .i_res_r(o_res_r),
    .i_count(queue_i.count)
);

// File: tb/taylor_checker.sv
// reference model of the stereo taylor series; compares each result pair in arrival order
`timescale 1ns/1ps

module taylor_checker #(
    parameter int N_TERMS = 10
) (
    input  logic                                 reset,
    input  logic                                 clk,
    input  logic                                 i_req_valid,
    input  taylor_pkg::func_t                    i_func,
    input  logic signed [taylor_pkg::DATA_W-1:0] i_x_l,
    input  logic signed [taylor_pkg::DATA_W-1:0] i_x_r,
    input  logic                                 i_res_valid,
    input  logic signed [taylor_pkg::DATA_W-1:0] i_res_l,
    input  logic signed [taylor_pkg::DATA_W-1:0] i_res_r,
    output int                                   o_errors,
    output int                                   o_checked,
    output int                                   o_pending
);
    import taylor_pkg::*;

    // both series are centred on zero
    localparam longint A0 = 0;

    logic signed [DATA_W-1:0] exp_l [$];
    logic signed [DATA_W-1:0] exp_r [$];
    int errors = 0;
    int checked = 0;

    assign o_errors  = errors;
    assign o_checked = checked;

    // keep bits 33..16 of a product
    function automatic longint trunc_q(input longint p);
        logic signed [DATA_W-1:0] k;
        k = p[FRAC_W+DATA_W-1:FRAC_W];
        return longint'(k);
    endfunction

    // n-th derivative at zero, sin runs 0 1 0 -1 and cos runs 1 0 -1 0
    function automatic longint deriv_sign(input func_t f, input int n);
        case (n % 4)
            0:       return (f == FUNC_COS) ? 1 : 0;
            1:       return (f == FUNC_COS) ? 0 : 1;
            2:       return (f == FUNC_COS) ? -1 : 0;
            default: return (f == FUNC_COS) ? 0 : -1;
        endcase
    endfunction

    function automatic logic signed [DATA_W-1:0] series(
        input func_t                    f,
        input logic signed [DATA_W-1:0] x
    );
        longint xa;
        longint val;
        longint sum;
        xa  = longint'(x) - A0;
        val = longint'(ONE_Q);
        sum = deriv_sign(f, 0) * longint'(ONE_Q);
        for (int n = 1; n <= N_TERMS; n++) begin
            // reciprocal factor is 1/n truncated to the sample format
            val = trunc_q(trunc_q(val * (longint'(ONE_Q) / n)) * xa);
            sum = sum + deriv_sign(f, n) * val;
        end
        return DATA_W'(sum);
    endfunction

    always @(posedge reset or posedge clk) begin
        if (clk) begin
            exp_l.delete();
            exp_r.delete();
        end else begin
            if (i_res_valid) begin
                if (exp_l.size() == 0) begin
                    $display("%0t: a result arrived with no request outstanding", $time);
                    errors++;
                end else begin
                    if (i_res_l !== exp_l[0] || i_res_r !== exp_r[0]) begin
                        $display("Mismatch at %0t: left %0d expected %0d, right %0d expected %0d",
                                 $time, i_res_l, exp_l[0], i_res_r, exp_r[0]);
                        errors++;
                    end
                    void'(exp_l.pop_front());
                    void'(exp_r.pop_front());
                    checked++;
                end
            end
            if (i_req_valid) begin
                exp_l.push_back(series(i_func, i_x_l));
                exp_r.push_back(series(i_func, i_x_r));
            end
        end
        o_pending = exp_l.size();
    end

endmodule

// File: source/taylor_top.sv
// top level of the stereo sine/cosine unit, credit-flow requests in, one-cycle results out
`timescale 1ns/1ps

module taylor_top (
    input  logic                                 reset,
    input  logic                                 clk,
    input  logic                                 i_req_valid,
    input  taylor_pkg::func_t                    i_func,
    input  logic signed [taylor_pkg::DATA_W-1:0] i_x_l,
    input  logic signed [taylor_pkg::DATA_W-1:0] i_x_r,
    output logic                                 o_credit,
    output logic                                 o_res_valid,
    output logic signed [taylor_pkg::DATA_W-1:0] o_res_l,
    output logic signed [taylor_pkg::DATA_W-1:0] o_res_r
);
    import taylor_pkg::*;

    localparam int N_TERMS     = 10;
    localparam int QUEUE_DEPTH = 4;

    logic                     q_valid;
    logic                     q_take;
    func_t                    q_func;
    logic signed [DATA_W-1:0] q_x_l, q_x_r;
    logic [IDX_W-1:0]         coef_idx;
    func_t                    coef_func;
    logic signed [DATA_W-1:0] coef, a0;
    logic signed [1:0]        sign;

    dsp_pair_if dsp_bus ();

    request_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_i (
        .reset(reset), .clk(clk),
        .i_push(i_req_valid), .i_func(i_func), .i_x_l(i_x_l), .i_x_r(i_x_r),
        .i_take(q_take), .o_valid(q_valid), .o_func(q_func),
        .o_x_l(q_x_l), .o_x_r(q_x_r), .o_credit(o_credit)
    );

    taylor_engine #(.N_TERMS(N_TERMS)) engine_i (
        .reset(reset), .clk(clk),
        .i_valid(q_valid), .i_func(q_func), .i_x_l(q_x_l), .i_x_r(q_x_r),
        .o_take(q_take), .o_idx(coef_idx), .o_func(coef_func),
        .i_coef(coef), .i_sign(sign), .i_a0(a0), .dsp(dsp_bus.engine),
        .o_res_valid(o_res_valid), .o_res_l(o_res_l), .o_res_r(o_res_r)
    );

    taylor_coefs #(.N_TERMS(N_TERMS)) coefs_i (
        .i_func(coef_func), .i_idx(coef_idx),
        .o_coef(coef), .o_sign(sign), .o_a0(a0)
    );

    dsp_pair slice_i (
        .reset(reset), .clk(clk), .dsp(dsp_bus.slice)
    );

endmodule

// File: source/request_queue.sv
// circular request buffer in front of the engine, returns one credit per entry taken
`timescale 1ns/1ps

module request_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                                 reset,
    input  logic                                 clk,
    input  logic                                 i_push,
    input  taylor_pkg::func_t                    i_func,
    input  logic signed [taylor_pkg::DATA_W-1:0] i_x_l,
    input  logic signed [taylor_pkg::DATA_W-1:0] i_x_r,
    input  logic                                 i_take,
    output logic                                 o_valid,
    output taylor_pkg::func_t                    o_func,
    output logic signed [taylor_pkg::DATA_W-1:0] o_x_l,
    output logic signed [taylor_pkg::DATA_W-1:0] o_x_r,
    output logic                                 o_credit
);
    import taylor_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    func_t                    func_mem [QUEUE_DEPTH];
    logic signed [DATA_W-1:0] xl_mem   [QUEUE_DEPTH];
    logic signed [DATA_W-1:0] xr_mem   [QUEUE_DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [CNT_W-1:0]         count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge reset) begin
        if (i_push) begin
            func_mem[wr_ptr] <= i_func;
            xl_mem[wr_ptr]   <= i_x_l;
            xr_mem[wr_ptr]   <= i_x_r;
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (i_take) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count    <= count + CNT_W'(i_push) - CNT_W'(i_take);
            o_credit <= i_take;
        end
    end

    assign o_valid = (count != '0);
    assign o_func  = func_mem[rd_ptr];
    assign o_x_l   = xl_mem[rd_ptr];
    assign o_x_r   = xr_mem[rd_ptr];

endmodule

// File: source/taylor_engine.sv
// microcoded sequencer running the taylor series on both channels through the shared slice
`timescale 1ns/1ps

module taylor_engine #(
    parameter int N_TERMS = 10
) (
    input  logic                                 reset,
    input  logic                                 clk,
    input  logic                                 i_valid,
    input  taylor_pkg::func_t                    i_func,
    input  logic signed [taylor_pkg::DATA_W-1:0] i_x_l,
    input  logic signed [taylor_pkg::DATA_W-1:0] i_x_r,
    output logic                                 o_take,
    output logic [taylor_pkg::IDX_W-1:0]         o_idx,
    output taylor_pkg::func_t                    o_func,
    input  logic signed [taylor_pkg::DATA_W-1:0] i_coef,
    input  logic signed [1:0]                    i_sign,
    input  logic signed [taylor_pkg::DATA_W-1:0] i_a0,
    dsp_pair_if.engine                           dsp,
    output logic                                 o_res_valid,
    output logic signed [taylor_pkg::DATA_W-1:0] o_res_l,
    output logic signed [taylor_pkg::DATA_W-1:0] o_res_r
);
    import taylor_pkg::*;

    // ------------------------------------------------------------
    // microcode
    // ------------------------------------------------------------
    localparam logic [2:0] PC_WAIT   = 3'd0;
    localparam logic [2:0] PC_SUB    = 3'd1;
    localparam logic [2:0] PC_MUL_R  = 3'd2;
    localparam logic [2:0] PC_MAC    = 3'd3;
    localparam logic [2:0] PC_MUL_XA = 3'd4;
    localparam logic [2:0] PC_LOOP   = 3'd5;

    typedef enum logic [1:0] {
        TAG_NONE,
        TAG_XA,
        TAG_VAL,
        TAG_ACC
    } tag_t;

    typedef struct packed {
        logic sub_xa;
        logic mul_r;
        logic mac;
        logic mul_xa;
        logic inc_i;
        logic post;
    } uop_t;

    logic [2:0]         pc;
    uop_t               uop;
    logic [IDX_W-1:0]   idx;
    logic [IDX_W-1:0]   rep_cnt;
    logic               last;
    tag_t               tag_in;
    tag_t               tag_q [2];
    func_t              func_q;

    logic signed [DATA_W-1:0] x_l, x_r;
    logic signed [DATA_W-1:0] xa_l, xa_r;
    logic signed [DATA_W-1:0] val_l, val_r;
    logic signed [ACC_W-1:0]  acc_l, acc_r;
    logic signed [DATA_W-1:0] pk_l, pk_r;
    logic signed [DATA_W-1:0] sign_q;

    // last pass only folds the final term into the sum
    assign last   = (rep_cnt == '0);
    assign o_take = (pc == PC_WAIT) && i_valid;

    always_comb begin
        uop = '0;
        case (pc)
            PC_SUB:    uop.sub_xa = 1'b1;
            PC_MUL_R:  uop.mul_r  = !last;
            PC_MAC:    uop.mac    = 1'b1;
            PC_MUL_XA: begin
                uop.mul_xa = !last;
                uop.inc_i  = !last;
            end
            PC_LOOP:   uop.post   = last;
            default:   uop = '0;
        endcase
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pc      <= PC_WAIT;
            idx     <= '0;
            rep_cnt <= '0;
            func_q  <= FUNC_SIN;
        end else begin
            case (pc)
                PC_WAIT: begin
                    if (i_valid) begin
                        pc     <= PC_SUB;
                        func_q <= i_func;
                    end
                end
                PC_SUB: begin
                    pc      <= PC_MUL_R;
                    idx     <= '0;
                    rep_cnt <= IDX_W'(N_TERMS);
                end
                PC_LOOP: begin
                    pc <= last ? PC_WAIT : PC_MUL_R;
                    if (!last) begin
                        rep_cnt <= rep_cnt - 1'b1;
                    end
                end
                default: pc <= pc + 3'd1;
            endcase
            if (uop.inc_i) begin
                idx <= idx + 1'b1;
            end
        end
    end

    // rom lookup, the multiply step prefetches the next reciprocal
    assign o_idx  = uop.mul_r ? idx + 1'b1 : idx;
    assign o_func = func_q;

    // ------------------------------------------------------------
    // slice operands
    // ------------------------------------------------------------
    assign pk_l = dsp.p_l[FRAC_W+DATA_W-1:FRAC_W];
    assign pk_r = dsp.p_r[FRAC_W+DATA_W-1:FRAC_W];

    always_comb begin
        case (i_sign)
            2'sb01:  sign_q = ONE_Q;
            2'sb11:  sign_q = -ONE_Q;
            default: sign_q = '0;
        endcase
    end

    always_comb begin
        dsp.op = '0;
        dsp.a_l = '0;
        dsp.b_l = '0;
        dsp.c_l = '0;
        dsp.a_r = '0;
        dsp.b_r = '0;
        dsp.c_r = '0;
        tag_in = TAG_NONE;
        if (uop.sub_xa) begin
            // xa = x - a0*1
            dsp.op  = '{mult_en: 1'b1, add_c: 1'b1, sub: 1'b1};
            dsp.a_l = i_a0;
            dsp.a_r = i_a0;
            dsp.b_l = ONE_Q;
            dsp.b_r = ONE_Q;
            dsp.c_l = {{(ACC_W-DATA_W-FRAC_W){x_l[DATA_W-1]}}, x_l, {FRAC_W{1'b0}}};
            dsp.c_r = {{(ACC_W-DATA_W-FRAC_W){x_r[DATA_W-1]}}, x_r, {FRAC_W{1'b0}}};
            tag_in  = TAG_XA;
        end else if (uop.mul_r) begin
            dsp.op  = '{mult_en: 1'b1, add_c: 1'b0, sub: 1'b0};
            dsp.a_l = (idx == '0) ? ONE_Q : pk_l;
            dsp.a_r = (idx == '0) ? ONE_Q : pk_r;
            dsp.b_l = i_coef;
            dsp.b_r = i_coef;
        end else if (uop.mac) begin
            dsp.op  = '{mult_en: 1'b1, add_c: 1'b1, sub: 1'b0};
            dsp.a_l = sign_q;
            dsp.a_r = sign_q;
            dsp.b_l = val_l;
            dsp.b_r = val_r;
            dsp.c_l = acc_l;
            dsp.c_r = acc_r;
            tag_in  = TAG_ACC;
        end else if (uop.mul_xa) begin
            // product of the previous step feeds straight back
            dsp.op  = '{mult_en: 1'b1, add_c: 1'b0, sub: 1'b0};
            dsp.a_l = pk_l;
            dsp.a_r = pk_r;
            dsp.b_l = xa_l;
            dsp.b_r = xa_r;
            tag_in  = TAG_VAL;
        end
    end

    // ------------------------------------------------------------
    // write-back, tags follow the two slice stages
    // ------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            tag_q[0] <= TAG_NONE;
            tag_q[1] <= TAG_NONE;
        end else begin
            tag_q[0] <= tag_in;
            tag_q[1] <= tag_q[0];
        end
    end

    always_ff @(posedge reset) begin
        if (o_take) begin
            x_l <= i_x_l;
            x_r <= i_x_r;
        end
        if (uop.sub_xa) begin
            val_l <= ONE_Q;
            val_r <= ONE_Q;
            acc_l <= '0;
            acc_r <= '0;
        end
        case (tag_q[1])
            TAG_XA: begin
                xa_l <= pk_l;
                xa_r <= pk_r;
            end
            TAG_VAL: begin
                val_l <= pk_l;
                val_r <= pk_r;
            end
            TAG_ACC: begin
                acc_l <= dsp.p_l;
                acc_r <= dsp.p_r;
            end
            default: ;
        endcase
    end

    // one-cycle result pulse, zero otherwise
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            o_res_valid <= 1'b0;
            o_res_l     <= '0;
            o_res_r     <= '0;
        end else if (uop.post) begin
            o_res_valid <= 1'b1;
            o_res_l     <= pk_l;
            o_res_r     <= pk_r;
        end else begin
            o_res_valid <= 1'b0;
            o_res_l     <= '0;
            o_res_r     <= '0;
        end
    end

endmodule

// File: source/taylor_coefs.sv
// coefficient rom: reciprocal factor, derivative sign at a0, and a0 per function and index
`timescale 1ns/1ps

module taylor_coefs #(
    parameter int N_TERMS = 10
) (
    input  taylor_pkg::func_t                   i_func,
    input  logic [taylor_pkg::IDX_W-1:0]        i_idx,
    output logic signed [taylor_pkg::DATA_W-1:0] o_coef,
    output logic signed [1:0]                   o_sign,
    output logic signed [taylor_pkg::DATA_W-1:0] o_a0
);
    import taylor_pkg::*;

    logic [1:0] phase;

    // 1/idx truncated, zero outside the series
    always_comb begin
        case (i_idx)
            4'd1:    o_coef = 18'sh10000;
            4'd2:    o_coef = 18'sh08000;
            4'd3:    o_coef = 18'sh05555;
            4'd4:    o_coef = 18'sh04000;
            4'd5:    o_coef = 18'sh03333;
            4'd6:    o_coef = 18'sh02aaa;
            4'd7:    o_coef = 18'sh02492;
            4'd8:    o_coef = 18'sh02000;
            4'd9:    o_coef = 18'sh01c71;
            4'd10:   o_coef = 18'sh01999;
            4'd11:   o_coef = 18'sh01745;
            4'd12:   o_coef = 18'sh01555;
            default: o_coef = '0;
        endcase
        if (i_idx > IDX_W'(N_TERMS)) begin
            o_coef = '0;
        end
    end

    // derivatives of sin at zero repeat 0, +1, 0, -1; cos is one step ahead
    assign phase = i_idx[1:0] + ((i_func == FUNC_COS) ? 2'd1 : 2'd0);

    always_comb begin
        case (phase)
            2'd1:    o_sign = 2'sb01;
            2'd3:    o_sign = 2'sb11;
            default: o_sign = 2'sb00;
        endcase
    end

    // both series centred on zero
    assign o_a0 = '0;

endmodule

// File: source/dsp_pair.sv
// two-lane multiply-add slice, p = c +/- a*b with two cycles of latency, shared opcode
`timescale 1ns/1ps

module dsp_pair (
    input  logic       reset,
    input  logic       clk,
    dsp_pair_if.slice  dsp
);
    import taylor_pkg::*;

    localparam int LANES = 2;

    logic signed [DATA_W-1:0] a_in [LANES];
    logic signed [DATA_W-1:0] b_in [LANES];
    logic signed [ACC_W-1:0]  c_in [LANES];
    logic signed [ACC_W-1:0]  p_q  [LANES];
    dsp_op_t                  op_q;

    // lane 0 is left, lane 1 is right
    assign a_in[0] = dsp.a_l;
    assign b_in[0] = dsp.b_l;
    assign c_in[0] = dsp.c_l;
    assign a_in[1] = dsp.a_r;
    assign b_in[1] = dsp.b_r;
    assign c_in[1] = dsp.c_r;
    assign dsp.p_l = p_q[0];
    assign dsp.p_r = p_q[1];

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            op_q <= '0;
        end else begin
            op_q <= dsp.op;
        end
    end

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        logic signed [DATA_W-1:0]   a_q;
        logic signed [DATA_W-1:0]   b_q;
        logic signed [ACC_W-1:0]    c_q;
        logic signed [2*DATA_W-1:0] prod;
        logic signed [ACC_W-1:0]    x_w;
        logic signed [ACC_W-1:0]    z_w;

        // stage one, operand registers
        always_ff @(posedge reset) begin
            a_q <= a_in[g];
            b_q <= b_in[g];
            c_q <= c_in[g];
        end

        assign prod = a_q * b_q;
        assign x_w  = op_q.mult_en ? ACC_W'(prod) : '0;
        assign z_w  = op_q.add_c ? c_q : '0;

        // stage two, post-adder output
        always_ff @(posedge reset) begin
            p_q[g] <= op_q.sub ? (z_w - x_w) : (z_w + x_w);
        end
    end

endmodule

// File: source/dsp_pair_if.sv
// operand and product bus between the series engine and the dual multiply-add slice
`timescale 1ns/1ps

interface dsp_pair_if;

    taylor_pkg::dsp_op_t op;

    // left lane
    logic signed [taylor_pkg::DATA_W-1:0] a_l;
    logic signed [taylor_pkg::DATA_W-1:0] b_l;
    logic signed [taylor_pkg::ACC_W-1:0]  c_l;
    logic signed [taylor_pkg::ACC_W-1:0]  p_l;

    // right lane
    logic signed [taylor_pkg::DATA_W-1:0] a_r;
    logic signed [taylor_pkg::DATA_W-1:0] b_r;
    logic signed [taylor_pkg::ACC_W-1:0]  c_r;
    logic signed [taylor_pkg::ACC_W-1:0]  p_r;

    modport engine (output op, a_l, b_l, c_l, a_r, b_r, c_r, input p_l, p_r);
    modport slice  (input op, a_l, b_l, c_l, a_r, b_r, c_r, output p_l, p_r);

endinterface

// File: source/taylor_pkg.sv
// shared widths, selector and slice opcode types for the stereo taylor series datapath
package taylor_pkg;

    // sample format: signed, 16 fraction bits
    localparam int DATA_W = 18;
    localparam int FRAC_W = 16;
    localparam int ACC_W  = 48;

    localparam logic signed [DATA_W-1:0] ONE_Q = 18'sh10000;

    // rom depth, also the upper bound for the series length
    localparam int MAX_TERMS = 12;

    // index runs one past the last term when the engine prefetches
    localparam int IDX_W = $clog2(MAX_TERMS + 2);

    typedef enum logic {
        FUNC_SIN = 1'b0,
        FUNC_COS = 1'b1
    } func_t;

    // slice opcode
    typedef struct packed {
        logic mult_en;
        logic add_c;
        logic sub;
    } dsp_op_t;

endpackage
